// File: hw/board_pkg.sv
package board_pkg;

    // Bus and memory sizes
    localparam int data_w       = 32;
    localparam int ram_words    = 1024;
    localparam int sd_buf_bytes = 512;

    // Region tags in address bits 31:28
    localparam logic [3:0] region_ram = 4'd0;
    localparam logic [3:0] region_io  = 4'd1;
    localparam logic [3:0] region_sd  = 4'd2;

    // Word registers inside the IO region
    localparam logic [2:0] io_key      = 3'd0;
    localparam logic [2:0] io_console  = 3'd1;
    localparam logic [2:0] io_sd_addr  = 3'd2;
    localparam logic [2:0] io_sd_read  = 3'd3;
    localparam logic [2:0] io_sd_ready = 3'd4;
    localparam logic [2:0] io_sd_avail = 3'd5;

    // Decoder FSM states
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_issue = 2'd1;
    localparam logic [1:0] st_wait  = 2'd2;
    localparam logic [1:0] st_ack   = 2'd3;

    // Device chosen for the current access
    localparam logic [1:0] tgt_none = 2'd0;
    localparam logic [1:0] tgt_ram  = 2'd1;
    localparam logic [1:0] tgt_io   = 2'd2;
    localparam logic [1:0] tgt_sd   = 2'd3;

    // One bus address, three ways to slice it
    typedef union packed {
        struct packed {
            logic [3:0]  tag;
            logic [15:0] pad;
            logic [9:0]  word;
            logic [1:0]  off;
        } ram;
        struct packed {
            logic [3:0]  tag;
            logic [22:0] pad;
            logic [2:0]  idx;
            logic [1:0]  off;
        } io;
        struct packed {
            logic [3:0]  tag;
            logic [18:0] pad;
            logic [8:0]  byte_idx;
        } sd;
    } bus_addr_u;

endpackage

// File: hw/periph_bus_if.sv
`timescale 1ns/1ps

interface periph_bus_if
    import board_pkg::*;
();

    // Request side, driven by the decoder
    logic              sel;
    logic              we;
    bus_addr_u         addr;
    logic [data_w-1:0] wdata;

    // Answer side, driven by the device
    logic [data_w-1:0] rdata;
    logic              done;

    modport host (
        output sel,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  done
    );

    modport dev (
        input  sel,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output done
    );

endinterface

// File: hw/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder
    import board_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              bus_req,
    input  logic              bus_we,
    input  logic [31:0]       bus_addr,
    input  logic [data_w-1:0] bus_wdata,
    output logic              bus_ack,
    output logic [data_w-1:0] bus_rdata,
    periph_bus_if.host        ram_bus,
    periph_bus_if.host        io_bus,
    periph_bus_if.host        sd_bus
);

    bus_addr_u         addr_view;
    logic [1:0]        state;
    logic [1:0]        tgt;
    logic [1:0]        next_tgt;
    logic              tgt_done;
    logic [data_w-1:0] tgt_rdata;

    assign addr_view = bus_addr;

    // Region decode; IO indices for the SD block go to the SD device
    always_comb begin
        case (addr_view.ram.tag)
            region_ram: next_tgt = tgt_ram;
            region_io: begin
                if (addr_view.io.idx >= io_sd_addr && addr_view.io.idx <= io_sd_avail)
                    next_tgt = tgt_sd;
                else
                    next_tgt = tgt_io;
            end
            region_sd: next_tgt = tgt_sd;
            default:   next_tgt = tgt_none;
        endcase
    end

    // Master fields are stable for the whole request
    assign ram_bus.addr  = addr_view;
    assign ram_bus.we    = bus_we;
    assign ram_bus.wdata = bus_wdata;
    assign io_bus.addr   = addr_view;
    assign io_bus.we     = bus_we;
    assign io_bus.wdata  = bus_wdata;
    assign sd_bus.addr   = addr_view;
    assign sd_bus.we     = bus_we;
    assign sd_bus.wdata  = bus_wdata;

    // One-cycle select toward the chosen device
    assign ram_bus.sel = (state == st_issue) && (tgt == tgt_ram);
    assign io_bus.sel  = (state == st_issue) && (tgt == tgt_io);
    assign sd_bus.sel  = (state == st_issue) && (tgt == tgt_sd);

    always_comb begin
        case (tgt)
            tgt_ram: begin
                tgt_done  = ram_bus.done;
                tgt_rdata = ram_bus.rdata;
            end
            tgt_io: begin
                tgt_done  = io_bus.done;
                tgt_rdata = io_bus.rdata;
            end
            tgt_sd: begin
                tgt_done  = sd_bus.done;
                tgt_rdata = sd_bus.rdata;
            end
            default: begin
                tgt_done  = 1'b0;
                tgt_rdata = '0;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state     <= st_idle;
            tgt       <= tgt_none;
            bus_ack   <= 1'b0;
            bus_rdata <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (bus_req && !bus_ack) begin
                        tgt   <= next_tgt;
                        state <= st_issue;
                    end
                end
                st_issue: begin
                    // Unmapped space answers at once with zero
                    if (tgt == tgt_none) begin
                        bus_rdata <= '0;
                        bus_ack   <= 1'b1;
                        state     <= st_ack;
                    end else begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (tgt_done) begin
                        bus_rdata <= tgt_rdata;
                        bus_ack   <= 1'b1;
                        state     <= st_ack;
                    end
                end
                st_ack: begin
                    if (!bus_req) begin
                        bus_ack <= 1'b0;
                        state   <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: hw/ram_block.sv
`timescale 1ns/1ps

module ram_block
    import board_pkg::*;
(
    input  logic      CLOCK_50,
    periph_bus_if.dev bus
);

    logic [data_w-1:0] mem [ram_words];
    logic [9:0]        word_idx;

    assign word_idx = bus.addr.ram.word;

    // Single-port synchronous RAM, read data one cycle after select
    always_ff @(posedge CLOCK_50) begin
        if (bus.sel && bus.we) begin
            mem[word_idx] <= bus.wdata;
        end
        bus.rdata <= mem[word_idx];
        bus.done  <= bus.sel;
    end

endmodule

// File: hw/io_regs.sv
`timescale 1ns/1ps

module io_regs
    import board_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       KEY0,
    periph_bus_if.dev  bus,
    input  logic [7:0] key_code,
    input  logic       key_valid,
    output logic [3:0] irq_vector,
    input  logic       irq_ack,
    output logic [7:0] console_byte,
    output logic       console_valid
);

    logic [7:0] key_last;
    logic       console_wr;

    assign console_wr = bus.sel && bus.we && (bus.addr.io.idx == io_console);

    // Keyboard latch and interrupt
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_last   <= 8'd0;
            irq_vector <= 4'd0;
        end else begin
            if (key_valid) begin
                key_last <= key_code;
                if (key_code != 8'd0) begin
                    irq_vector <= 4'd1;
                end
            end
            // Acknowledge wins over a new key in the same cycle
            if (irq_vector != 4'd0 && irq_ack) begin
                irq_vector <= 4'd0;
            end
        end
    end

    // Console strobe and bus answer
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            console_valid <= 1'b0;
            bus.done      <= 1'b0;
        end else begin
            console_valid <= console_wr;
            bus.done      <= bus.sel;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (console_wr) begin
            console_byte <= bus.wdata[7:0];
        end
        if (bus.addr.io.idx == io_key)
            bus.rdata <= {{(data_w - 8){1'b0}}, key_last};
        else
            bus.rdata <= '0;
    end

endmodule

// File: hw/sd_sector_buffer.sv
`timescale 1ns/1ps

module sd_sector_buffer
    import board_pkg::*;
(
    input  logic        CLOCK_50,
    input  logic        KEY0,
    periph_bus_if.dev   bus,
    input  logic [7:0]  sd_byte,
    input  logic        sd_byte_toggle,
    input  logic        sd_ready,
    output logic        sd_rd_start,
    output logic [31:0] sd_addr
);

    logic [7:0]                        sector [sd_buf_bytes];
    logic [$clog2(sd_buf_bytes)-1:0]   wr_idx;
    logic                              avail;
    logic [7:0]                        byte_s1;
    logic [7:0]                        byte_s2;
    logic                              tog_s1;
    logic                              tog_s2;
    logic                              tog_s3;
    logic                              byte_edge;
    logic                              io_hit;
    logic                              addr_wr;
    logic                              read_wr;

    assign io_hit    = bus.addr.io.tag == region_io;
    assign addr_wr   = bus.sel && bus.we && io_hit && (bus.addr.io.idx == io_sd_addr);
    assign read_wr   = bus.sel && bus.we && io_hit && (bus.addr.io.idx == io_sd_read);
    assign byte_edge = tog_s2 ^ tog_s3;

    // Two-stage sync on the byte stream, third stage finds the toggle
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            tog_s1 <= 1'b0;
            tog_s2 <= 1'b0;
            tog_s3 <= 1'b0;
        end else begin
            tog_s1 <= sd_byte_toggle;
            tog_s2 <= tog_s1;
            tog_s3 <= tog_s2;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        byte_s1 <= sd_byte;
        byte_s2 <= byte_s1;
    end

    // Control registers, capture index and bus handshake
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sd_addr     <= 32'd0;
            sd_rd_start <= 1'b0;
            wr_idx      <= '0;
            avail       <= 1'b0;
            bus.done    <= 1'b0;
        end else begin
            bus.done    <= bus.sel;
            sd_rd_start <= read_wr;
            if (addr_wr) begin
                sd_addr <= bus.wdata;
            end
            if (byte_edge) begin
                if (wr_idx == sd_buf_bytes - 1) begin
                    wr_idx <= '0;
                    avail  <= 1'b1;
                end else begin
                    wr_idx <= wr_idx + 1'b1;
                end
            end
            // New read request restarts the sector
            if (read_wr) begin
                wr_idx <= '0;
                avail  <= 1'b0;
            end
        end
    end

    // Sector storage and read mux
    always_ff @(posedge CLOCK_50) begin
        if (byte_edge) begin
            sector[wr_idx] <= byte_s2;
        end
        if (bus.addr.sd.tag == region_sd) begin
            bus.rdata <= {{(data_w - 8){1'b0}}, sector[bus.addr.sd.byte_idx]};
        end else begin
            case (bus.addr.io.idx)
                io_sd_addr:  bus.rdata <= sd_addr;
                io_sd_ready: bus.rdata <= {{(data_w - 1){1'b0}}, sd_ready};
                io_sd_avail: bus.rdata <= {{(data_w - 1){1'b0}}, avail};
                default:     bus.rdata <= '0;
            endcase
        end
    end

endmodule

// File: hw/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic        bus_req,
    input  logic        bus_we,
    input  logic [31:0] bus_addr,
    input  logic [31:0] bus_wdata,
    output logic        bus_ack,
    output logic [31:0] bus_rdata,
    input  logic [7:0]  key_code,
    input  logic        key_valid,
    output logic [3:0]  irq_vector,
    input  logic        irq_ack,
    output logic [7:0]  console_byte,
    output logic        console_valid,
    input  logic [7:0]  sd_byte,
    input  logic        sd_byte_toggle,
    input  logic        sd_ready,
    output logic        sd_rd_start,
    output logic [31:0] sd_addr
);

    periph_bus_if ram_bus ();
    periph_bus_if io_bus ();
    periph_bus_if sd_bus ();

    bus_decoder u_decoder (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .bus_req   (bus_req),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata),
        .ram_bus   (ram_bus.host),
        .io_bus    (io_bus.host),
        .sd_bus    (sd_bus.host)
    );

    ram_block u_ram (
        .CLOCK_50 (CLOCK_50),
        .bus      (ram_bus.dev)
    );

    io_regs u_io (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .bus           (io_bus.dev),
        .key_code      (key_code),
        .key_valid     (key_valid),
        .irq_vector    (irq_vector),
        .irq_ack       (irq_ack),
        .console_byte  (console_byte),
        .console_valid (console_valid)
    );

    sd_sector_buffer u_sd (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .bus            (sd_bus.dev),
        .sd_byte        (sd_byte),
        .sd_byte_toggle (sd_byte_toggle),
        .sd_ready       (sd_ready),
        .sd_rd_start    (sd_rd_start),
        .sd_addr        (sd_addr)
    );

endmodule

// File: tb/soc_bus_props.sv
`timescale 1ns/1ps

module soc_bus_props (
    input logic CLOCK_50,
    input logic KEY0,
    input logic bus_req,
    input logic bus_ack,
    input logic console_valid,
    input logic sd_rd_start
);

    // Four-phase master handshake
    ack_rise_with_req: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(bus_ack) |-> bus_req)
        else $error("bus_ack rose while bus_req was low");

    ack_fall_after_req: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $fell(bus_ack) |-> $past(!bus_req))
        else $error("bus_ack fell before bus_req had fallen");

    // Single-cycle strobes
    console_one_cycle: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        console_valid |=> !console_valid)
        else $error("console_valid lasted more than one cycle");

    rd_start_one_cycle: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_rd_start |=> !sd_rd_start)
        else $error("sd_rd_start lasted more than one cycle");

endmodule

bind soc_bus_top soc_bus_props u_props (.*);

// File: tb/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;

    logic        CLOCK_50;
    logic        KEY0;
    logic        bus_req;
    logic        bus_we;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic        bus_ack;
    logic [31:0] bus_rdata;
    logic [7:0]  key_code;
    logic        key_valid;
    logic [3:0]  irq_vector;
    logic        irq_ack;
    logic [7:0]  console_byte;
    logic        console_valid;
    logic [7:0]  sd_byte;
    logic        sd_byte_toggle;
    logic        sd_ready;
    logic        sd_rd_start;
    logic [31:0] sd_addr;

    // Reference model state
    logic [31:0] ram_model [1024];
    bit          ram_written [1024];
    int          ram_used [$];
    logic [7:0]  sector_model [512];

    logic [31:0] seed;
    logic [31:0] val;
    int          idx;
    int          cycles;
    int          console_pulses;
    int          start_pulses;
    int          pulses_before;
    logic [7:0]  console_seen;

    soc_bus_top dut (.*);

    always #2 CLOCK_50 = ~CLOCK_50;

    // About 900 transfers plus the sector stream fit well below this
    always @(posedge CLOCK_50) begin
        cycles <= cycles + 1;
        if (cycles >= 40000) begin
            $display("ERROR: timeout, the run did not finish within 40000 cycles");
            $display("Test failures found");
            $fatal(1);
        end
    end

    // Count output strobes
    always @(posedge CLOCK_50) begin
        if (console_valid) begin
            console_pulses <= console_pulses + 1;
            console_seen   <= console_byte;
        end
        if (sd_rd_start)
            start_pulses <= start_pulses + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // One complete four-phase transfer
    task automatic bus_xfer(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge CLOCK_50);
        bus_req   <= 1'b1;
        bus_we    <= we;
        bus_addr  <= addr;
        bus_wdata <= wdata;
        do @(posedge CLOCK_50); while (!bus_ack);
        rdata = bus_rdata;
        bus_req <= 1'b0;
        do @(posedge CLOCK_50); while (bus_ack);
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_xfer(1'b1, addr, data, unused);
    endtask

    task automatic read_check(input string name, input logic [31:0] addr,
                              input logic [31:0] expected);
        logic [31:0] got;
        bus_xfer(1'b0, addr, 32'd0, got);
        check(name, expected, got);
    endtask

    initial begin
        CLOCK_50       = 1'b0;
        KEY0           = 1'b0;
        bus_req        = 1'b0;
        bus_we         = 1'b0;
        bus_addr       = 32'd0;
        bus_wdata      = 32'd0;
        key_code       = 8'd0;
        key_valid      = 1'b0;
        irq_ack        = 1'b0;
        sd_byte        = 8'd0;
        sd_byte_toggle = 1'b0;
        sd_ready       = 1'b0;
        cycles         = 0;
        console_pulses = 0;
        start_pulses   = 0;
        seed           = 32'h29bf_2e4b;
        repeat (3) @(posedge CLOCK_50);
        KEY0 <= 1'b1;

        // RAM writes, then reads of written words only
        for (int i = 0; i < 200; i++) begin
            seed = xorshift(seed);
            idx  = seed[9:0];
            seed = xorshift(seed);
            if (!ram_written[idx]) begin
                ram_used.push_back(idx);
            end
            ram_written[idx] = 1'b1;
            ram_model[idx]   = seed;
            bus_write({20'd0, 10'(idx), 2'b00}, seed);
        end
        for (int i = 0; i < 200; i++) begin
            seed = xorshift(seed);
            idx  = ram_used[seed % ram_used.size()];
            read_check("ram_read", {20'd0, 10'(idx), 2'b00}, ram_model[idx]);
        end

        // Keyboard latch and interrupt
        // Every fourth code is zero
        for (int i = 0; i < 8; i++) begin
            seed = xorshift(seed);
            val  = (i % 4 == 0) ? 32'd0 : {24'd0, seed[7:0]};
            @(posedge CLOCK_50);
            key_code  <= val[7:0];
            key_valid <= 1'b1;
            @(posedge CLOCK_50);
            key_valid <= 1'b0;
            read_check("key_read", 32'h1000_0000, val);
            check("irq_after_key", (val != 0) ? 32'd1 : 32'd0, {28'd0, irq_vector});
            if (val != 0) begin
                repeat (2) @(posedge CLOCK_50);
                check("irq_held", 32'd1, {28'd0, irq_vector});
                irq_ack <= 1'b1;
                @(posedge CLOCK_50);
                irq_ack <= 1'b0;
                @(posedge CLOCK_50);
                check("irq_cleared", 32'd0, {28'd0, irq_vector});
            end
        end

        // Console strobe
        for (int i = 0; i < 20; i++) begin
            seed          = xorshift(seed);
            pulses_before = console_pulses;
            bus_write(32'h1000_0004, seed);
            check("console_pulses", pulses_before + 1, console_pulses);
            check("console_byte", {24'd0, seed[7:0]}, {24'd0, console_seen});
        end

        // SD control registers
        for (int i = 0; i < 10; i++) begin
            seed = xorshift(seed);
            bus_write(32'h1000_0008, seed);
            check("sd_addr_port", seed, sd_addr);
            read_check("sd_addr_read", 32'h1000_0008, seed);
            pulses_before = start_pulses;
            bus_write(32'h1000_000C, 32'd0);
            check("sd_rd_start", pulses_before + 1, start_pulses);
            seed = xorshift(seed);
            @(posedge CLOCK_50);
            sd_ready <= seed[0];
            read_check("sd_ready", 32'h1000_0010, {31'd0, seed[0]});
        end

        // Sector capture with one toggle every 5 cycles
        for (int i = 0; i < 512; i++) begin
            seed            = xorshift(seed);
            sector_model[i] = seed[7:0];
            @(posedge CLOCK_50);
            sd_byte        <= seed[7:0];
            sd_byte_toggle <= ~sd_byte_toggle;
            repeat (4) @(posedge CLOCK_50);
        end
        repeat (4) @(posedge CLOCK_50);
        read_check("sd_avail_set", 32'h1000_0014, 32'd1);
        for (int i = 0; i < 100; i++) begin
            seed = xorshift(seed);
            idx  = seed[8:0];
            read_check("sd_buffer", {4'h2, 19'd0, 9'(idx)}, {24'd0, sector_model[idx]});
        end

        // A new read request drops avail of the full sector
        pulses_before = start_pulses;
        bus_write(32'h1000_000C, 32'd0);
        check("sd_rd_start_full", pulses_before + 1, start_pulses);
        read_check("sd_avail_clear", 32'h1000_0014, 32'd0);

        // Tags 3 to 15 are unmapped
        for (int i = 0; i < 20; i++) begin
            seed = xorshift(seed);
            val  = {4'(3 + seed[31:28] % 13), seed[27:0]};
            read_check("unmapped_read", val, 32'd0);
            seed = xorshift(seed);
            bus_write(val, seed);
        end
        for (int i = 0; i < ram_used.size(); i++) begin
            idx = ram_used[i];
            read_check("ram_after_unmapped", {20'd0, 10'(idx), 2'b00}, ram_model[idx]);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: compile.f
hw/board_pkg.sv
hw/periph_bus_if.sv
hw/bus_decoder.sv
hw/ram_block.sv
hw/io_regs.sv
hw/sd_sector_buffer.sv
hw/soc_bus_top.sv
tb/soc_bus_props.sv
tb/tb_soc_bus.sv
